// File: test/ising_cases.txt
// J rows 0..7, J_ij of column j at nibble j (signed), then h with h_i at nibble i,
// then scaling, case count, and per case: spin en_comparison icon_count icons (all hex)
3e21f0a0
c4f2170a
2a0e03f1
f1b0e230
052d0e21
e0f1d201
1e30f20d
0d2e1c3f
// h
1f3e20d1
// scaling
3
// number of cases
5
// comparison on, single flips
a5 1 5
01 02 04 08 10
// comparison on, pair flips
3c 1 6
81 42 24 18 03 c0
// comparison off, last candidate wins
f0 0 4
0f 11 22 44
// no icons, initial spin only
00 1 0
// full icon memory
5a 1 10
01 02 04 08 10 20 40 80
03 0c 30 c0 06 18 60 81

// File: verilog.f
common/ising_pkg.sv
weight_fetch/weight_fetch.sv
energy_monitor/energy_monitor.sv
flip_manager/flip_manager.sv
hdl/ising_macro.sv
test/tb_ising_macro.sv

// File: run.sh
#!/bin/sh
# build and run the Ising macro testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_ising_macro
out=$(./obj_dir/Vtb_ising_macro 2>&1) || true
echo "$out"
if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: test/tb_ising_macro.sv
/*
 * testbench for the Ising macro
 * clock and reset, J and flip icon memory models,
 * reference energy model and result checks
 */

`timescale 1ns/1ps

module tb_ising_macro;

    localparam int CLK_PERIOD   = 100;
    localparam int RESULT_LIMIT = 200;
    localparam int IDLE_LIMIT   = 20;
    localparam int NUM_SPIN     = ising_pkg::NUM_SPIN;
    localparam int BITJ         = ising_pkg::BITJ;
    localparam int PARALLELISM  = ising_pkg::PARALLELISM;
    localparam int WORDS        = NUM_SPIN / PARALLELISM;
    localparam int ROW_BITS     = NUM_SPIN * BITJ;
    localparam int CASE_BASE    = NUM_SPIN + 3;

    logic                      clk_i;
    logic                      arst_n_i;
    logic                      flush_i;
    logic                      config_valid_i;
    ising_pkg::spin_t          config_spin_i;
    logic                      cmpt_en_i;
    logic                      en_comparison_i;
    logic [4:0]                icon_last_raddr_plus_one_i;
    ising_pkg::hbias_t         hbias_i;
    ising_pkg::scaling_t       hscaling_i;
    logic                      j_ren_o;
    ising_pkg::j_addr_t        j_raddr_o;
    ising_pkg::j_word_t        j_rdata_i;
    logic                      flip_ren_o;
    ising_pkg::icon_addr_t     flip_raddr_o;
    ising_pkg::spin_t          flip_rdata_i;
    logic                      cmpt_idle_o;
    logic                      result_valid_o;
    ising_pkg::energy_result_t result_o;
    ising_pkg::energy_result_t best_o;

    logic [31:0]           data_mem [0:255];
    logic [ROW_BITS-1:0]   j_rows [NUM_SPIN];
    ising_pkg::j_word_t    j_mem [WORDS];
    ising_pkg::spin_t      icon_mem [16];
    logic [31:0]           h_vec;
    ising_pkg::scaling_t   scale;
    int                    num_cases;
    int                    ptr;
    ising_pkg::spin_t      case_spin;
    logic                  case_cmp;
    int                    case_count;
    logic                  j_req;
    ising_pkg::j_addr_t    j_req_addr;
    logic                  icon_req;
    ising_pkg::icon_addr_t icon_req_addr;

    ising_macro #(
        .NUM_SPIN    (NUM_SPIN),
        .PARALLELISM (PARALLELISM)
    ) uut (
        .clk_i                      (clk_i),
        .arst_n_i                   (arst_n_i),
        .flush_i                    (flush_i),
        .config_valid_i             (config_valid_i),
        .config_spin_i              (config_spin_i),
        .cmpt_en_i                  (cmpt_en_i),
        .en_comparison_i            (en_comparison_i),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .hbias_i                    (hbias_i),
        .hscaling_i                 (hscaling_i),
        .j_ren_o                    (j_ren_o),
        .j_raddr_o                  (j_raddr_o),
        .j_rdata_i                  (j_rdata_i),
        .flip_ren_o                 (flip_ren_o),
        .flip_raddr_o               (flip_raddr_o),
        .flip_rdata_i               (flip_rdata_i),
        .cmpt_idle_o                (cmpt_idle_o),
        .result_valid_o             (result_valid_o),
        .result_o                   (result_o),
        .best_o                     (best_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // requests sampled mid-cycle, data shows up after the next edge
    always begin
        @(negedge clk_i);
        j_req         = j_ren_o;
        j_req_addr    = j_raddr_o;
        icon_req      = flip_ren_o;
        icon_req_addr = flip_raddr_o;
        @(posedge clk_i);
        #1;
        if (j_req) begin
            j_rdata_i = j_mem[j_req_addr];
        end
        if (icon_req) begin
            flip_rdata_i = icon_mem[icon_req_addr];
        end
    end

    // sum over rows of s_i * (sum_j J_ij s_j + scaling * h_i)
    function automatic int ref_energy(ising_pkg::spin_t s);
        int                     e;
        int                     row_sum;
        int                     val;
        logic signed [BITJ-1:0] nib;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            nib     = h_vec[i*BITJ +: BITJ];
            val     = nib;
            row_sum = val * int'(scale);
            for (int j = 0; j < NUM_SPIN; j++) begin
                nib     = j_rows[i][j*BITJ +: BITJ];
                val     = nib;
                row_sum = s[j] ? row_sum + val : row_sum - val;
            end
            e = s[i] ? e + row_sum : e - row_sum;
        end
        return e;
    endfunction

    task automatic report_error(string what);
        $display("Error at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic read_case();
        case_spin  = data_mem[ptr][NUM_SPIN-1:0];
        case_cmp   = data_mem[ptr+1][0];
        case_count = int'(data_mem[ptr+2]);
        ptr += 3;
        assert (case_count <= 16) else report_error("icon count above memory depth");
        for (int k = 0; k < case_count; k++) begin
            icon_mem[k] = data_mem[ptr][NUM_SPIN-1:0];
            ptr++;
        end
    endtask

    task automatic start_run();
        step();
        config_valid_i             = 1'b1;
        config_spin_i              = case_spin;
        en_comparison_i            = case_cmp;
        icon_last_raddr_plus_one_i = 5'(case_count);
        step();
        config_valid_i = 1'b0;
        cmpt_en_i      = 1'b1;
        step();
        cmpt_en_i = 1'b0;
    endtask

    task automatic wait_result(int index);
        int waited;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
            if (waited > RESULT_LIMIT) begin
                report_error($sformatf("result %0d did not arrive in time", index));
            end
        end while (!result_valid_o);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
            assert (!result_valid_o) else report_error("more results than expected");
            if (waited > IDLE_LIMIT) begin
                report_error("cmpt_idle_o did not return high");
            end
        end while (!cmpt_idle_o);
    endtask

    task automatic run_checked();
        ising_pkg::spin_t best_spin;
        ising_pkg::spin_t exp_spin;
        int               best_e;
        int               exp_e;
        best_spin = case_spin;
        best_e    = 0;
        start_run();
        for (int n = 0; n <= case_count; n++) begin
            exp_spin = (n == 0) ? case_spin : best_spin ^ icon_mem[n-1];
            exp_e    = ref_energy(exp_spin);
            wait_result(n);
            check_value("result_o.spin", exp_spin, result_o.spin);
            check_value("result_o.energy", exp_e, int'(result_o.energy));
            check_value("cmpt_idle_o", 0, cmpt_idle_o);
            // initial spin always taken, later ones only when strictly lower
            if (n == 0 || !case_cmp || exp_e < best_e) begin
                best_spin = exp_spin;
                best_e    = exp_e;
            end
        end
        wait_idle();
        check_value("best_o.spin", best_spin, best_o.spin);
        check_value("best_o.energy", best_e, int'(best_o.energy));
    endtask

    task automatic run_flushed();
        int stop_after;
        stop_after = $urandom_range(1, case_count);
        start_run();
        for (int n = 0; n < stop_after; n++) begin
            wait_result(n);
        end
        step();
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        wait_idle();
        check_value("best_o.energy", 32'h7fff, int'(best_o.energy));
    endtask

    initial begin
        void'($urandom(32'h1d8f_6d3b));
        clk_i                      = 1'b0;
        arst_n_i                   = 1'b0;
        flush_i                    = 1'b0;
        config_valid_i             = 1'b0;
        config_spin_i              = '0;
        cmpt_en_i                  = 1'b0;
        en_comparison_i            = 1'b0;
        icon_last_raddr_plus_one_i = '0;
        hbias_i                    = '0;
        hscaling_i                 = '0;
        j_rdata_i                  = '0;
        flip_rdata_i               = '0;

        $readmemh("test/ising_cases.txt", data_mem);
        for (int i = 0; i < NUM_SPIN; i++) begin
            j_rows[i] = data_mem[i];
        end
        h_vec     = data_mem[NUM_SPIN];
        scale     = data_mem[NUM_SPIN+1][ising_pkg::SCALING_BIT-1:0];
        num_cases = int'(data_mem[NUM_SPIN+2]);
        assert (num_cases > 0) else
            report_error("case file test/ising_cases.txt holds no cases");
        for (int w = 0; w < WORDS; w++) begin
            for (int r = 0; r < PARALLELISM; r++) begin
                j_mem[w][r*ROW_BITS +: ROW_BITS] = j_rows[w*PARALLELISM + r];
            end
        end
        for (int a = 0; a < 16; a++) begin
            icon_mem[a] = {4'(a), ~4'(a)};
        end
        hbias_i    = h_vec;
        hscaling_i = scale;

        repeat (8) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("cmpt_idle_o", 1, cmpt_idle_o);
        check_value("result_valid_o", 0, result_valid_o);
        check_value("j_ren_o", 0, j_ren_o);
        check_value("flip_ren_o", 0, flip_ren_o);

        ptr = CASE_BASE;
        for (int c = 0; c < num_cases; c++) begin
            read_case();
            run_checked();
            repeat ($urandom_range(0, 3)) step();
        end

        // abort the first case mid-run, then run it again
        ptr = CASE_BASE;
        read_case();
        run_flushed();
        run_checked();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: hdl/ising_macro.sv
/*
 * Ising machine digital compute path
 * weight fetch, energy monitor and flip manager
 */

`timescale 1ns/1ps

module ising_macro #(
    parameter int NUM_SPIN    = ising_pkg::NUM_SPIN,
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           flush_i,
    // configuration
    input  logic                           config_valid_i,
    input  ising_pkg::spin_t               config_spin_i,
    input  logic                           cmpt_en_i,
    input  logic                           en_comparison_i,
    input  logic [ising_pkg::ICON_ADDR_BIT:0] icon_last_raddr_plus_one_i,
    input  ising_pkg::hbias_t              hbias_i,
    input  ising_pkg::scaling_t            hscaling_i,
    // J memory
    output logic                           j_ren_o,
    output ising_pkg::j_addr_t             j_raddr_o,
    input  ising_pkg::j_word_t             j_rdata_i,
    // flip icon memory
    output logic                           flip_ren_o,
    output ising_pkg::icon_addr_t          flip_raddr_o,
    input  ising_pkg::spin_t               flip_rdata_i,
    // status and results
    output logic                           cmpt_idle_o,
    output logic                           result_valid_o,
    output ising_pkg::energy_result_t      result_o,
    output ising_pkg::energy_result_t      best_o
);

    logic                      weight_valid;
    logic                      weight_ready;
    ising_pkg::j_word_t        weight;
    logic                      spin_valid;
    logic                      spin_ready;
    ising_pkg::spin_t          spin;
    logic                      energy_valid;
    logic                      energy_ready;
    ising_pkg::energy_result_t energy;

    weight_fetch #(
        .NUM_SPIN    (NUM_SPIN),
        .PARALLELISM (PARALLELISM)
    ) u_weight_fetch (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .j_ren_o        (j_ren_o),
        .j_raddr_o      (j_raddr_o),
        .j_rdata_i      (j_rdata_i),
        .weight_valid_o (weight_valid),
        .weight_o       (weight),
        .weight_ready_i (weight_ready)
    );

    energy_monitor #(
        .NUM_SPIN    (NUM_SPIN),
        .PARALLELISM (PARALLELISM)
    ) u_energy_monitor (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .spin_valid_i   (spin_valid),
        .spin_i         (spin),
        .spin_ready_o   (spin_ready),
        .weight_valid_i (weight_valid),
        .weight_i       (weight),
        .weight_ready_o (weight_ready),
        .hbias_i        (hbias_i),
        .hscaling_i     (hscaling_i),
        .energy_valid_o (energy_valid),
        .energy_o       (energy),
        .energy_ready_i (energy_ready)
    );

    flip_manager #(
        .NUM_SPIN (NUM_SPIN)
    ) u_flip_manager (
        .clk_i                      (clk_i),
        .arst_n_i                   (arst_n_i),
        .flush_i                    (flush_i),
        .config_valid_i             (config_valid_i),
        .config_spin_i              (config_spin_i),
        .cmpt_en_i                  (cmpt_en_i),
        .en_comparison_i            (en_comparison_i),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .flip_ren_o                 (flip_ren_o),
        .flip_raddr_o               (flip_raddr_o),
        .flip_rdata_i               (flip_rdata_i),
        .spin_valid_o               (spin_valid),
        .spin_o                     (spin),
        .spin_ready_i               (spin_ready),
        .energy_valid_i             (energy_valid),
        .energy_i                   (energy),
        .energy_ready_o             (energy_ready),
        .cmpt_idle_o                (cmpt_idle_o),
        .result_valid_o             (result_valid_o),
        .result_o                   (result_o),
        .best_o                     (best_o)
    );

endmodule

// File: flip_manager/flip_manager.sv
/*
 * Spin search controller
 * initial spin evaluation, icon based candidates,
 * energy comparison and the best result register
 */

`timescale 1ns/1ps

module flip_manager #(
    parameter int NUM_SPIN = ising_pkg::NUM_SPIN
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           flush_i,
    // configuration
    input  logic                           config_valid_i,
    input  ising_pkg::spin_t               config_spin_i,
    input  logic                           cmpt_en_i,
    input  logic                           en_comparison_i,
    input  logic [ising_pkg::ICON_ADDR_BIT:0] icon_last_raddr_plus_one_i,
    // flip icon memory
    output logic                           flip_ren_o,
    output ising_pkg::icon_addr_t          flip_raddr_o,
    input  ising_pkg::spin_t               flip_rdata_i,
    // candidate to energy monitor
    output logic                           spin_valid_o,
    output ising_pkg::spin_t               spin_o,
    input  logic                           spin_ready_i,
    // energy back
    input  logic                           energy_valid_i,
    input  ising_pkg::energy_result_t      energy_i,
    output logic                           energy_ready_o,
    // status and results
    output logic                           cmpt_idle_o,
    output logic                           result_valid_o,
    output ising_pkg::energy_result_t      result_o,
    output ising_pkg::energy_result_t      best_o
);

    localparam ising_pkg::energy_t ENERGY_MAX = {1'b0, {(ising_pkg::ENERGY_BIT-1){1'b1}}};

    ising_pkg::fm_state_e              state_q;
    logic                              cmpt_en_dly_q;
    logic                              start;
    logic [ising_pkg::ICON_ADDR_BIT:0] icon_cnt_q;
    logic                              icon_pend_q;
    logic                              spin_valid_q;
    logic [NUM_SPIN-1:0]               cand_q;
    ising_pkg::spin_t                  init_spin_q;
    ising_pkg::energy_result_t         best_q;
    ising_pkg::energy_result_t         result_q;
    logic                              result_valid_q;
    logic                              energy_hsk;
    logic                              accept;
    logic                              last_icon;

    assign start      = cmpt_en_i & ~cmpt_en_dly_q;
    assign energy_hsk = energy_valid_i & energy_ready_o;
    // strictly lower wins, or anything when comparison is off
    assign accept     = ~en_comparison_i | (energy_i.energy < best_q.energy);
    assign last_icon  = (icon_cnt_q == icon_last_raddr_plus_one_i);

    assign energy_ready_o = ((state_q == ising_pkg::eval_init) |
                             (state_q == ising_pkg::eval_cand)) & ~spin_valid_q;
    assign flip_ren_o     = (state_q == ising_pkg::fetch_icon) & ~icon_pend_q;
    assign flip_raddr_o   = icon_cnt_q[ising_pkg::ICON_ADDR_BIT-1:0];

    assign spin_valid_o   = spin_valid_q;
    assign spin_o         = cand_q;
    assign cmpt_idle_o    = (state_q == ising_pkg::idle);
    assign result_valid_o = result_valid_q;
    assign result_o       = result_q;
    assign best_o         = best_q;

    // edge detect survives flush so a held enable does not restart
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmpt_en_dly_q <= 1'b0;
        end else begin
            cmpt_en_dly_q <= cmpt_en_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= ising_pkg::idle;
            icon_cnt_q     <= '0;
            icon_pend_q    <= 1'b0;
            spin_valid_q   <= 1'b0;
            result_valid_q <= 1'b0;
            best_q         <= '{energy: ENERGY_MAX, spin: '0};
        end else if (flush_i) begin
            state_q        <= ising_pkg::idle;
            icon_cnt_q     <= '0;
            icon_pend_q    <= 1'b0;
            spin_valid_q   <= 1'b0;
            result_valid_q <= 1'b0;
            best_q         <= '{energy: ENERGY_MAX, spin: '0};
        end else begin
            result_valid_q <= energy_hsk;
            if (spin_valid_q && spin_ready_i) begin
                spin_valid_q <= 1'b0;
            end
            unique case (state_q)
                ising_pkg::idle: begin
                    if (start) begin
                        spin_valid_q <= 1'b1;
                        icon_cnt_q   <= '0;
                        state_q      <= ising_pkg::eval_init;
                    end
                end
                ising_pkg::eval_init, ising_pkg::eval_cand: begin
                    if (energy_hsk) begin
                        // initial spin is always taken as best
                        if (state_q == ising_pkg::eval_init || accept) begin
                            best_q <= energy_i;
                        end
                        state_q <= last_icon ? ising_pkg::done : ising_pkg::fetch_icon;
                    end
                end
                ising_pkg::fetch_icon: begin
                    // icon data is back one cycle after the read
                    if (icon_pend_q) begin
                        icon_pend_q  <= 1'b0;
                        spin_valid_q <= 1'b1;
                        icon_cnt_q   <= icon_cnt_q + 1'b1;
                        state_q      <= ising_pkg::eval_cand;
                    end else begin
                        icon_pend_q <= 1'b1;
                    end
                end
                ising_pkg::done: begin
                    state_q <= ising_pkg::idle;
                end
                default: begin
                    state_q <= ising_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (config_valid_i && state_q == ising_pkg::idle) begin
            init_spin_q <= config_spin_i;
        end
        if (energy_hsk) begin
            result_q <= energy_i;
        end
        if (state_q == ising_pkg::idle && start) begin
            cand_q <= init_spin_q;
        end else if (state_q == ising_pkg::fetch_icon && icon_pend_q) begin
            cand_q <= best_q.spin ^ flip_rdata_i;
        end
    end

endmodule

// File: energy_monitor/energy_monitor.sv
/*
 * Ising energy accumulator
 * one spin vector per run, PARALLELISM J rows per weight word
 */

`timescale 1ns/1ps

module energy_monitor #(
    parameter int NUM_SPIN    = ising_pkg::NUM_SPIN,
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      flush_i,
    // spin in
    input  logic                      spin_valid_i,
    input  ising_pkg::spin_t          spin_i,
    output logic                      spin_ready_o,
    // weights in
    input  logic                      weight_valid_i,
    input  ising_pkg::j_word_t        weight_i,
    output logic                      weight_ready_o,
    input  ising_pkg::hbias_t         hbias_i,
    input  ising_pkg::scaling_t       hscaling_i,
    // energy out
    output logic                      energy_valid_o,
    output ising_pkg::energy_result_t energy_o,
    input  logic                      energy_ready_i
);

    localparam int WORDS  = NUM_SPIN / PARALLELISM;
    localparam int CNT_W  = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam int BITJ   = ising_pkg::BITJ;

    logic               busy_q;
    logic               valid_q;
    logic [CNT_W-1:0]   word_cnt_q;
    ising_pkg::energy_t acc_q;
    ising_pkg::energy_t word_sum;
    ising_pkg::spin_t   spin_q;
    logic               spin_hsk;
    logic               weight_hsk;
    logic               last_word;

    // accepts a new vector only when idle
    assign spin_ready_o   = ~busy_q & ~valid_q;
    assign weight_ready_o = busy_q;
    assign spin_hsk       = spin_valid_i & spin_ready_o;
    assign weight_hsk     = weight_valid_i & weight_ready_o;
    assign last_word      = (word_cnt_q == CNT_W'(WORDS - 1));

    assign energy_valid_o  = valid_q;
    assign energy_o.energy = acc_q;
    assign energy_o.spin   = spin_q;

    // s_i * (sum_j J_ij s_j + scaling * h_i) over the rows of one word
    always_comb begin : word_energy
        ising_pkg::energy_t      row_sum;
        ising_pkg::energy_t      h_term;
        logic signed [BITJ-1:0]  j_val;
        logic signed [BITJ-1:0]  h_val;
        int                      row;
        word_sum = '0;
        for (int r = 0; r < PARALLELISM; r++) begin
            row     = int'(word_cnt_q) * PARALLELISM + r;
            h_val   = hbias_i[row*BITJ +: BITJ];
            h_term  = h_val * $signed({1'b0, hscaling_i});
            row_sum = h_term;
            for (int j = 0; j < NUM_SPIN; j++) begin
                j_val   = weight_i[(r*NUM_SPIN + j)*BITJ +: BITJ];
                row_sum = spin_q[j] ? row_sum + j_val : row_sum - j_val;
            end
            word_sum = spin_q[row] ? word_sum + row_sum : word_sum - row_sum;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            valid_q    <= 1'b0;
            word_cnt_q <= '0;
            acc_q      <= '0;
        end else if (flush_i) begin
            busy_q     <= 1'b0;
            valid_q    <= 1'b0;
            word_cnt_q <= '0;
            acc_q      <= '0;
        end else begin
            if (spin_hsk) begin
                busy_q     <= 1'b1;
                word_cnt_q <= '0;
                acc_q      <= '0;
            end else if (weight_hsk) begin
                acc_q      <= acc_q + word_sum;
                word_cnt_q <= last_word ? '0 : word_cnt_q + 1'b1;
                if (last_word) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end
            end
            if (valid_q && energy_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_hsk) begin
            spin_q <= spin_i;
        end
    end

endmodule

// File: weight_fetch/weight_fetch.sv
/*
 * J memory reader feeding a two-entry FIFO
 * addresses wrap so words always leave in row order
 */

`timescale 1ns/1ps

module weight_fetch #(
    parameter int NUM_SPIN    = ising_pkg::NUM_SPIN,
    parameter int PARALLELISM = ising_pkg::PARALLELISM
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               flush_i,
    // memory side
    output logic               j_ren_o,
    output ising_pkg::j_addr_t j_raddr_o,
    input  ising_pkg::j_word_t j_rdata_i,
    // stream side
    output logic               weight_valid_o,
    output ising_pkg::j_word_t weight_o,
    input  logic               weight_ready_i
);

    localparam int LAST_ADDR = NUM_SPIN / PARALLELISM - 1;

    ising_pkg::j_addr_t addr_q;
    logic               in_flight_q;
    logic [1:0]         usage_q;
    logic               wr_ptr_q;
    logic               rd_ptr_q;
    ising_pkg::j_word_t fifo_mem [2];
    logic               push;
    logic               pop;

    // read data lands one cycle after the request
    assign push = in_flight_q;
    assign pop  = weight_valid_o & weight_ready_i;

    assign weight_valid_o = (usage_q != 2'd0);
    assign weight_o       = fifo_mem[rd_ptr_q];

    // room must cover stored words plus the one in flight
    assign j_ren_o   = weight_ready_i & ((usage_q + 2'(in_flight_q)) < (2'd2 + 2'(pop)));
    assign j_raddr_o = addr_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q      <= '0;
            in_flight_q <= 1'b0;
            usage_q     <= 2'd0;
            wr_ptr_q    <= 1'b0;
            rd_ptr_q    <= 1'b0;
        end else if (flush_i) begin
            // a word still in flight is dropped
            addr_q      <= '0;
            in_flight_q <= 1'b0;
            usage_q     <= 2'd0;
            wr_ptr_q    <= 1'b0;
            rd_ptr_q    <= 1'b0;
        end else begin
            in_flight_q <= j_ren_o;
            usage_q     <= usage_q + 2'(push) - 2'(pop);
            if (j_ren_o) begin
                addr_q <= (addr_q == ising_pkg::j_addr_t'(LAST_ADDR)) ? '0 : addr_q + 1'b1;
            end
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= j_rdata_i;
        end
    end

endmodule

// File: common/ising_pkg.sv
/*
 * Ising macro shared definitions
 * widths, vector typedefs, the energy result struct
 * and the flip manager state encoding
 */

package ising_pkg;

    // problem size
    localparam int NUM_SPIN    = 8;
    localparam int BITJ        = 4;
    localparam int PARALLELISM = 2;

    // arithmetic widths
    localparam int SCALING_BIT = 4;
    localparam int ENERGY_BIT  = 16;

    // memory address widths
    localparam int J_ADDR_BIT    = $clog2(NUM_SPIN / PARALLELISM);
    localparam int ICON_ADDR_BIT = 4;

    // bit set means spin +1, clear means spin -1
    typedef logic [NUM_SPIN-1:0] spin_t;

    typedef logic signed [ENERGY_BIT-1:0] energy_t;

    // row r of a word is J row addr*PARALLELISM+r, column j at bit j*BITJ
    typedef logic [PARALLELISM*NUM_SPIN*BITJ-1:0] j_word_t;

    typedef logic [J_ADDR_BIT-1:0] j_addr_t;

    typedef logic [ICON_ADDR_BIT-1:0] icon_addr_t;

    // h_i at bit i*BITJ, signed
    typedef logic [NUM_SPIN*BITJ-1:0] hbias_t;

    typedef logic [SCALING_BIT-1:0] scaling_t;

    typedef struct packed {
        energy_t energy;
        spin_t   spin;
    } energy_result_t;

    typedef enum logic [2:0] {
        idle,
        eval_init,
        fetch_icon,
        eval_cand,
        done
    } fm_state_e;

endpackage
